// ==== dualIssueCore.f ====
rtl/dualIssuePkg.sv
rtl/regFile.sv
rtl/pairFetch.sv
rtl/issueDecode.sv
rtl/executeLanes.sv
rtl/retireStage.sv
rtl/dualIssueCore.sv
tb/tbClock.sv
tb/dualIssueCore_checker.sv
tb/dualIssueCore_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := dualIssueCore_tb
FILELIST  := dualIssueCore.f
FLAGS     := --binary --assert --top-module $(TOP)
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/dualIssueCore_tb.sv ====
module dualIssueCore_tb import dualIssuePkg::*; ();

    localparam word_t RESET_PC        = 32'hBFC0_0000;
    localparam int    PERIOD          = 20;
    localparam int    RESET_CYCLES    = 10;
    localparam int    DIRECTED_PAIRS  = 14;
    localparam int    RANDOM_PAIRS    = 400;
    localparam int    TOTAL_PAIRS     = DIRECTED_PAIRS + RANDOM_PAIRS;
    // a pair costs at most one split cycle and one idle cycle
    localparam int    WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_PAIRS * 4 + 50;

    logic        clk;
    logic        reset;
    logic        pairValid;
    word_t       inst0;
    word_t       inst1;
    logic        pairReady;
    logic        retireValid0;
    logic        retireValid1;
    regAddr_t    retireReg0;
    regAddr_t    retireReg1;
    word_t       retireData0;
    word_t       retireData1;
    word_t       retirePc0;
    word_t       retirePc1;

    word_t       modelRegs [32];
    word_t       modelPc;
    regAddr_t    expReg [$];       // expected retirements, program order
    word_t       expData [$];
    word_t       expPc [$];
    logic        splitPending;     // last accepted pair still owes its lane 1 cycle
    int          mismatchCount;
    int          otherCount;
    logic [15:0] lfsrState;

    tbClock #(
        .PERIOD       (PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk_o   (clk),
        .reset_o (reset)
    );

    dualIssueCore #(
        .RESET_PC (RESET_PC)
    ) u_dut (
        .clk            (clk),
        .reset_i        (reset),
        .pairValid_i    (pairValid),
        .inst0_i        (inst0),
        .inst1_i        (inst1),
        .pairReady_o    (pairReady),
        .retireValid0_o (retireValid0),
        .retireValid1_o (retireValid1),
        .retireReg0_o   (retireReg0),
        .retireReg1_o   (retireReg1),
        .retireData0_o  (retireData0),
        .retireData1_o  (retireData1),
        .retirePc0_o    (retirePc0),
        .retirePc1_o    (retirePc1)
    );

    bind dualIssueCore dualIssueCore_checker u_checker (
        .clk            (clk),
        .reset_i        (reset_i),
        .pairReady_i    (pairReady_o),
        .retireValid0_i (retireValid0_o),
        .retireValid1_i (retireValid1_o),
        .retireReg0_i   (retireReg0_o),
        .retireReg1_i   (retireReg1_o),
        .retirePc0_i    (retirePc0_o),
        .retirePc1_i    (retirePc1_o)
    );

    function automatic word_t encodeR(logic [5:0] funct, regAddr_t rd, regAddr_t rs,
                                      regAddr_t rt);
        return {6'h00, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic word_t encodeI(logic [5:0] op, regAddr_t rt, regAddr_t rs,
                                      logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value     = {value[30:0], lfsrState[0]};
        end
    endtask

    // applies one instruction to the model registers in program order
    function automatic void refApply(input word_t inst, output regAddr_t dest,
                                     output word_t data, output logic write);
        word_t       a;
        word_t       b;
        logic [15:0] imm;
        a     = modelRegs[inst[25:21]];
        b     = modelRegs[inst[20:16]];
        imm   = inst[15:0];
        dest  = inst[20:16];       // rt for immediates
        data  = '0;
        write = 1'b1;
        case (opcode_t'(inst[31:26]))
            OP_SPECIAL: begin
                dest = inst[15:11];
                case (funct_t'(inst[5:0]))
                    FN_ADDU: data = a + b;
                    FN_SUBU: data = a - b;
                    FN_AND:  data = a & b;
                    FN_OR:   data = a | b;
                    FN_XOR:  data = a ^ b;
                    FN_SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: write = 1'b0;
                endcase
            end
            OP_ADDIU: data = a + {{16{imm[15]}}, imm};
            OP_ANDI:  data = a & {16'h0000, imm};
            OP_ORI:   data = a | {16'h0000, imm};
            OP_LUI:   data = {imm, 16'h0000};
            default:  write = 1'b0;
        endcase
        if (dest == 5'd0) begin
            write = 1'b0;
        end
        if (write) begin
            modelRegs[dest] = data;
        end
    endfunction

    // true when a supported instruction takes r as a source
    function automatic logic readsReg(input word_t inst, input regAddr_t r);
        logic hit;
        hit = 1'b0;
        case (opcode_t'(inst[31:26]))
            OP_SPECIAL: begin
                case (funct_t'(inst[5:0]))
                    FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT:
                        hit = (inst[25:21] == r) || (inst[20:16] == r);
                    default: hit = 1'b0;
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI: hit = (inst[25:21] == r);
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

    task automatic expectPair(input word_t i0, input word_t i1, output logic split);
        regAddr_t dest;
        word_t    data;
        logic     write;
        refApply(i0, dest, data, write);
        split = write && readsReg(i1, dest);   // lane 1 needs lane 0's new value
        if (write) begin
            expReg.push_back(dest);
            expData.push_back(data);
            expPc.push_back(modelPc);
        end
        refApply(i1, dest, data, write);
        if (write) begin
            expReg.push_back(dest);
            expData.push_back(data);
            expPc.push_back(modelPc + 32'd4);
        end
        modelPc = modelPc + 32'd8;
    endtask

    // called in rising edge context, returns on the accepting edge
    task automatic sendPair(input word_t i0, input word_t i1);
        logic accepted;
        int   waits;
        int   expWaits;
        pairValid <= 1'b1;
        inst0     <= i0;
        inst1     <= i1;
        accepted  = 1'b0;
        waits     = 0;
        expWaits  = splitPending ? 1 : 0;
        while (!accepted) begin
            @(negedge clk);
            accepted = pairReady;  // settled until the next rising edge
            if (!accepted) begin
                waits++;
            end
            @(posedge clk);
        end
        assert (waits == expWaits) else begin
            otherCount++;
            $display("pair accepted after %0d wait cycles instead of %0d", waits, expWaits);
        end
        expectPair(i0, i1, splitPending);
    endtask

    // an idle cycle covers the split cycle of the pair before it
    task automatic idleCycle();
        pairValid    <= 1'b0;
        splitPending = 1'b0;
        @(posedge clk);
    endtask

    task automatic randomInst(output word_t inst);
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] imm;
        drawBits(4, kind);
        drawBits(3, rd);       // r0..r7, so r0 shows up now and then
        drawBits(3, rs);
        drawBits(3, rt);
        drawBits(16, imm);
        case (kind[3:0])
            4'd0, 4'd12: inst = encodeR(FN_ADDU, rd[4:0], rs[4:0], rt[4:0]);
            4'd1, 4'd13: inst = encodeR(FN_SUBU, rd[4:0], rs[4:0], rt[4:0]);
            4'd2:        inst = encodeR(FN_AND, rd[4:0], rs[4:0], rt[4:0]);
            4'd3:        inst = encodeR(FN_OR, rd[4:0], rs[4:0], rt[4:0]);
            4'd4:        inst = encodeR(FN_XOR, rd[4:0], rs[4:0], rt[4:0]);
            4'd5, 4'd14: inst = encodeR(FN_SLT, rd[4:0], rs[4:0], rt[4:0]);
            4'd6, 4'd15: inst = encodeI(OP_ADDIU, rt[4:0], rs[4:0], imm[15:0]);
            4'd7:        inst = encodeI(OP_ANDI, rt[4:0], rs[4:0], imm[15:0]);
            4'd8:        inst = encodeI(OP_ORI, rt[4:0], rs[4:0], imm[15:0]);
            4'd9:        inst = encodeI(OP_LUI, rt[4:0], 5'd0, imm[15:0]);
            4'd10:       inst = encodeI(6'h04, rt[4:0], rs[4:0], imm[15:0]);  // beq
            default:     inst = encodeR(6'h18, 5'd0, rs[4:0], rt[4:0]);       // mult
        endcase
    endtask

    task automatic runDirected();
        // register setup, r4 ends up negative
        sendPair(encodeI(OP_ADDIU, 5'd1, 5'd0, 16'h0123),
                 encodeI(OP_ADDIU, 5'd2, 5'd0, 16'hfff0));
        sendPair(encodeI(OP_ADDIU, 5'd3, 5'd0, 16'h7fff),
                 encodeI(OP_LUI, 5'd4, 5'd0, 16'h8000));
        sendPair(encodeI(OP_ORI, 5'd5, 5'd0, 16'ha5a5),
                 encodeI(OP_ADDIU, 5'd6, 5'd0, 16'h0005));
        sendPair(encodeI(OP_LUI, 5'd7, 5'd0, 16'h1234),
                 encodeI(OP_ORI, 5'd7, 5'd7, 16'h5678));   // split pair
        // signed compare both ways
        sendPair(encodeR(FN_SLT, 5'd1, 5'd4, 5'd3),
                 encodeR(FN_SLT, 5'd2, 5'd3, 5'd4));
        sendPair(encodeI(OP_ANDI, 5'd3, 5'd7, 16'hff00),
                 encodeR(FN_XOR, 5'd5, 5'd5, 5'd6));
        // dependent chain across back-to-back pairs
        sendPair(encodeR(FN_ADDU, 5'd1, 5'd6, 5'd7),
                 encodeR(FN_SUBU, 5'd2, 5'd7, 5'd6));
        sendPair(encodeR(FN_ADDU, 5'd3, 5'd1, 5'd2),
                 encodeR(FN_AND, 5'd4, 5'd2, 5'd1));
        sendPair(encodeR(FN_OR, 5'd5, 5'd3, 5'd4),
                 encodeR(FN_XOR, 5'd6, 5'd1, 5'd3));
        // same destination in both lanes
        sendPair(encodeI(OP_ADDIU, 5'd5, 5'd0, 16'h0011),
                 encodeI(OP_ADDIU, 5'd5, 5'd0, 16'h0022));
        sendPair(encodeR(FN_OR, 5'd6, 5'd5, 5'd0),
                 encodeR(FN_ADDU, 5'd7, 5'd5, 5'd5));
        // r0 targets and unsupported encodings
        sendPair(encodeI(OP_ADDIU, 5'd0, 5'd1, 16'h0007),
                 encodeI(6'h04, 5'd2, 5'd1, 16'h0010));
        sendPair(encodeR(FN_ADDU, 5'd2, 5'd0, 5'd0),
                 encodeR(6'h18, 5'd0, 5'd1, 5'd2));
        sendPair(encodeR(FN_OR, 5'd3, 5'd5, 5'd0),          // r5 from the register file
                 encodeI(OP_ADDIU, 5'd4, 5'd0, 16'h0001));
    endtask

    task automatic runRandom();
        word_t       i0;
        word_t       i1;
        logic [31:0] gap;
        int          n;
        for (n = 0; n < RANDOM_PAIRS; n++) begin
            randomInst(i0);
            randomInst(i1);
            sendPair(i0, i1);
            drawBits(3, gap);
            if (gap == 32'd0) begin
                idleCycle();
            end
        end
    endtask

    task automatic checkRetire(input int lane, input regAddr_t r, input word_t d,
                               input word_t pc);
        regAddr_t eReg;
        word_t    eData;
        word_t    ePc;
        assert (expReg.size() != 0) else begin
            otherCount++;
            $display("lane %0d retired a result although none was expected", lane);
        end
        if (expReg.size() != 0) begin
            eReg  = expReg.pop_front();
            eData = expData.pop_front();
            ePc   = expPc.pop_front();
            assert (r == eReg) else begin
                mismatchCount++;
                $display("mismatch retireReg%0d_o: got %h expected %h", lane, r, eReg);
            end
            assert (d == eData) else begin
                mismatchCount++;
                $display("mismatch retireData%0d_o: got %h expected %h", lane, d, eData);
            end
            assert (pc == ePc) else begin
                mismatchCount++;
                $display("mismatch retirePc%0d_o: got %h expected %h", lane, pc, ePc);
            end
        end
    endtask

    // retire ports are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset) begin
            if (retireValid0) begin
                checkRetire(0, retireReg0, retireData0, retirePc0);
            end
            if (retireValid1) begin
                checkRetire(1, retireReg1, retireData1, retirePc1);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        pairValid     <= 1'b0;
        inst0         <= '0;
        inst1         <= '0;
        splitPending  = 1'b0;
        mismatchCount = 0;
        otherCount    = 0;
        lfsrState     = 16'd3;
        modelPc       = RESET_PC;
        modelRegs     = '{default: '0};
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        runDirected();
        runRandom();
        pairValid <= 1'b0;
        while (expReg.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);   // pipeline depth, catches stray retirements
        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tb/dualIssueCore_checker.sv ====
module dualIssueCore_checker import dualIssuePkg::*; (
    input logic     clk,
    input logic     reset_i,
    input logic     pairReady_i,
    input logic     retireValid0_i,
    input logic     retireValid1_i,
    input regAddr_t retireReg0_i,
    input regAddr_t retireReg1_i,
    input word_t    retirePc0_i,
    input word_t    retirePc1_i
);

    // quiet outputs on the cycle after any reset edge
    assert property (@(posedge clk)
        reset_i |=> !pairReady_i && !retireValid0_i && !retireValid1_i)
        else $error("core outputs active right after reset");

    assert property (@(posedge clk) disable iff (reset_i)
        retireValid0_i |-> retireReg0_i != '0)
        else $error("lane 0 retired a write to register 0");

    assert property (@(posedge clk) disable iff (reset_i)
        retireValid1_i |-> retireReg1_i != '0)
        else $error("lane 1 retired a write to register 0");

    // lane 0 sits on a pair boundary, lane 1 four bytes above it
    assert property (@(posedge clk) disable iff (reset_i)
        retireValid0_i |-> retirePc0_i[2:0] == 3'b000)
        else $error("lane 0 retired with a misaligned pc");

    assert property (@(posedge clk) disable iff (reset_i)
        retireValid1_i |-> retirePc1_i[2:0] == 3'b100)
        else $error("lane 1 retired with a misaligned pc");

endmodule

// ==== tb/tbClock.sv ====
module tbClock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release on a rising edge, like the other stimulus
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== rtl/dualIssueCore.sv ====
module dualIssueCore import dualIssuePkg::*; #(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     pairValid_i,
    input  word_t    inst0_i,
    input  word_t    inst1_i,
    output logic     pairReady_o,
    output logic     retireValid0_o,
    output logic     retireValid1_o,
    output regAddr_t retireReg0_o,
    output regAddr_t retireReg1_o,
    output word_t    retireData0_o,
    output word_t    retireData1_o,
    output word_t    retirePc0_o,
    output word_t    retirePc1_o
);

    // decode stage
    logic     decValid0, decValid1;
    word_t    decInst0, decInst1;
    word_t    decPc0, decPc1;
    logic     splitNeeded;

    // execute stage
    logic     exValid0, exValid1;
    aluOp_t   exOp0, exOp1;
    word_t    exA0, exA1, exB0, exB1;
    regAddr_t exDest0, exDest1;
    word_t    exPc0, exPc1;
    word_t    exResult0, exResult1;
    logic     exWrite0, exWrite1;

    // writeback stage
    logic     wbValid0, wbValid1;
    regAddr_t wbReg0, wbReg1;
    word_t    wbData0, wbData1;

    pairFetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .pairValid_i   (pairValid_i),
        .inst0_i       (inst0_i),
        .inst1_i       (inst1_i),
        .splitNeeded_i (splitNeeded),
        .pairReady_o   (pairReady_o),
        .decValid0_o   (decValid0),
        .decValid1_o   (decValid1),
        .decInst0_o    (decInst0),
        .decInst1_o    (decInst1),
        .decPc0_o      (decPc0),
        .decPc1_o      (decPc1)
    );

    issueDecode u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .decValid0_i   (decValid0),
        .decValid1_i   (decValid1),
        .decInst0_i    (decInst0),
        .decInst1_i    (decInst1),
        .decPc0_i      (decPc0),
        .decPc1_i      (decPc1),
        .splitNeeded_o (splitNeeded),
        .exResult0_i   (exResult0),
        .exResult1_i   (exResult1),
        .wbValid0_i    (wbValid0),
        .wbValid1_i    (wbValid1),
        .wbReg0_i      (wbReg0),
        .wbReg1_i      (wbReg1),
        .wbData0_i     (wbData0),
        .wbData1_i     (wbData1),
        .exValid0_o    (exValid0),
        .exOp0_o       (exOp0),
        .exA0_o        (exA0),
        .exB0_o        (exB0),
        .exDest0_o     (exDest0),
        .exPc0_o       (exPc0),
        .exValid1_o    (exValid1),
        .exOp1_o       (exOp1),
        .exA1_o        (exA1),
        .exB1_o        (exB1),
        .exDest1_o     (exDest1),
        .exPc1_o       (exPc1)
    );

    executeLanes u_execute (
        .exValid0_i  (exValid0),
        .exOp0_i     (exOp0),
        .exA0_i      (exA0),
        .exB0_i      (exB0),
        .exDest0_i   (exDest0),
        .exValid1_i  (exValid1),
        .exOp1_i     (exOp1),
        .exA1_i      (exA1),
        .exB1_i      (exB1),
        .exDest1_i   (exDest1),
        .exResult0_o (exResult0),
        .exResult1_o (exResult1),
        .exWrite0_o  (exWrite0),
        .exWrite1_o  (exWrite1)
    );

    retireStage u_retire (
        .clk            (clk),
        .reset_i        (reset_i),
        .exResult0_i    (exResult0),
        .exResult1_i    (exResult1),
        .exWrite0_i     (exWrite0),
        .exWrite1_i     (exWrite1),
        .exDest0_i      (exDest0),
        .exDest1_i      (exDest1),
        .exPc0_i        (exPc0),
        .exPc1_i        (exPc1),
        .wbValid0_o     (wbValid0),
        .wbValid1_o     (wbValid1),
        .wbReg0_o       (wbReg0),
        .wbReg1_o       (wbReg1),
        .wbData0_o      (wbData0),
        .wbData1_o      (wbData1),
        .retireValid0_o (retireValid0_o),
        .retireValid1_o (retireValid1_o),
        .retireReg0_o   (retireReg0_o),
        .retireReg1_o   (retireReg1_o),
        .retireData0_o  (retireData0_o),
        .retireData1_o  (retireData1_o),
        .retirePc0_o    (retirePc0_o),
        .retirePc1_o    (retirePc1_o)
    );

endmodule

// ==== rtl/retireStage.sv ====
module retireStage import dualIssuePkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  word_t    exResult0_i,
    input  word_t    exResult1_i,
    input  logic     exWrite0_i,
    input  logic     exWrite1_i,
    input  regAddr_t exDest0_i,
    input  regAddr_t exDest1_i,
    input  word_t    exPc0_i,
    input  word_t    exPc1_i,
    output logic     wbValid0_o,
    output logic     wbValid1_o,
    output regAddr_t wbReg0_o,
    output regAddr_t wbReg1_o,
    output word_t    wbData0_o,
    output word_t    wbData1_o,
    output logic     retireValid0_o,
    output logic     retireValid1_o,
    output regAddr_t retireReg0_o,
    output regAddr_t retireReg1_o,
    output word_t    retireData0_o,
    output word_t    retireData1_o,
    output word_t    retirePc0_o,
    output word_t    retirePc1_o
);

    logic     valid0, valid1;
    regAddr_t dest0, dest1;
    word_t    data0, data1;
    word_t    pc0, pc1;

    // only writing instructions retire visibly
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end else begin
            valid0 <= exWrite0_i;
            valid1 <= exWrite1_i;
        end
    end

    always_ff @(posedge clk) begin
        dest0 <= exDest0_i;
        dest1 <= exDest1_i;
        data0 <= exResult0_i;
        data1 <= exResult1_i;
        pc0   <= exPc0_i;
        pc1   <= exPc1_i;
    end

    assign wbValid0_o = valid0;    // register file write and forwarding
    assign wbValid1_o = valid1;
    assign wbReg0_o   = dest0;
    assign wbReg1_o   = dest1;
    assign wbData0_o  = data0;
    assign wbData1_o  = data1;

    assign retireValid0_o = valid0;
    assign retireValid1_o = valid1;
    assign retireReg0_o   = dest0;
    assign retireReg1_o   = dest1;
    assign retireData0_o  = data0;
    assign retireData1_o  = data1;
    assign retirePc0_o    = pc0;
    assign retirePc1_o    = pc1;

endmodule

// ==== rtl/executeLanes.sv ====
module executeLanes import dualIssuePkg::*; (
    input  logic     exValid0_i,
    input  aluOp_t   exOp0_i,
    input  word_t    exA0_i,
    input  word_t    exB0_i,
    input  regAddr_t exDest0_i,
    input  logic     exValid1_i,
    input  aluOp_t   exOp1_i,
    input  word_t    exA1_i,
    input  word_t    exB1_i,
    input  regAddr_t exDest1_i,
    output word_t    exResult0_o,
    output word_t    exResult1_o,
    output logic     exWrite0_o,
    output logic     exWrite1_o
);

    function automatic word_t aluCompute(aluOp_t op, word_t a, word_t b);
        word_t result;
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};
            ALU_LUI: result = b;   // immediate already in the upper half
            default: result = '0;
        endcase
        return result;
    endfunction

    // master lane
    assign exResult0_o = aluCompute(exOp0_i, exA0_i, exB0_i);
    assign exWrite0_o  = exValid0_i && (exOp0_i != ALU_NOP) && (exDest0_i != '0);

    // slave lane
    assign exResult1_o = aluCompute(exOp1_i, exA1_i, exB1_i);
    assign exWrite1_o  = exValid1_i && (exOp1_i != ALU_NOP) && (exDest1_i != '0);

endmodule

// ==== rtl/issueDecode.sv ====
module issueDecode import dualIssuePkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     decValid0_i,
    input  logic     decValid1_i,
    input  word_t    decInst0_i,
    input  word_t    decInst1_i,
    input  word_t    decPc0_i,
    input  word_t    decPc1_i,
    output logic     splitNeeded_o,
    input  word_t    exResult0_i,
    input  word_t    exResult1_i,
    input  logic     wbValid0_i,
    input  logic     wbValid1_i,
    input  regAddr_t wbReg0_i,
    input  regAddr_t wbReg1_i,
    input  word_t    wbData0_i,
    input  word_t    wbData1_i,
    output logic     exValid0_o,
    output aluOp_t   exOp0_o,
    output word_t    exA0_o,
    output word_t    exB0_o,
    output regAddr_t exDest0_o,
    output word_t    exPc0_o,
    output logic     exValid1_o,
    output aluOp_t   exOp1_o,
    output word_t    exA1_o,
    output word_t    exB1_o,
    output regAddr_t exDest1_o,
    output word_t    exPc1_o
);

    aluOp_t   op0, op1;
    regAddr_t dest0, dest1;
    word_t    imm0, imm1;
    logic     useImm0, useImm1;
    logic     useRs0, useRs1;
    logic     useRt0, useRt1;
    regAddr_t rs0, rt0, rs1, rt1;
    word_t    rfRs0, rfRt0, rfRs1, rfRt1;
    word_t    srcA0, srcB0, srcA1, srcB1;

    // unsupported encodings leave op NOP and dest 0, so they never write
    function automatic void decodeInst(
        input  word_t    inst,
        output aluOp_t   op,
        output regAddr_t dest,
        output word_t    imm,
        output logic     useImm,
        output logic     useRs,
        output logic     useRt
    );
        op     = ALU_NOP;
        dest   = '0;
        imm    = '0;
        useImm = 1'b0;
        useRs  = 1'b0;
        useRt  = 1'b0;
        case (opcode_t'(inst[31:26]))
            OP_SPECIAL: begin
                case (funct_t'(inst[5:0]))
                    FN_ADDU: op = ALU_ADD;
                    FN_SUBU: op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_SLT:  op = ALU_SLT;
                    default: op = ALU_NOP;
                endcase
                dest  = (op == ALU_NOP) ? '0 : inst[15:11];
                useRs = (op != ALU_NOP);
                useRt = (op != ALU_NOP);
            end
            OP_ADDIU: begin
                op     = ALU_ADD;
                imm    = {{16{inst[15]}}, inst[15:0]};  // sign extend
                useRs  = 1'b1;
                useImm = 1'b1;
                dest   = inst[20:16];
            end
            OP_ANDI, OP_ORI: begin
                op     = (inst[26]) ? ALU_OR : ALU_AND;
                imm    = {16'h0000, inst[15:0]};        // zero extend
                useRs  = 1'b1;
                useImm = 1'b1;
                dest   = inst[20:16];
            end
            OP_LUI: begin
                op     = ALU_LUI;
                imm    = {inst[15:0], 16'h0000};
                useImm = 1'b1;
                dest   = inst[20:16];
            end
            default: ;
        endcase
    endfunction

    // youngest producer first
    function automatic word_t forwardSrc(regAddr_t src, word_t rfData);
        word_t value;
        if (src == '0) begin
            value = '0;
        end else if (exValid1_o && exDest1_o == src) begin
            value = exResult1_i;
        end else if (exValid0_o && exDest0_o == src) begin
            value = exResult0_i;
        end else if (wbValid1_i && wbReg1_i == src) begin
            value = wbData1_i;
        end else if (wbValid0_i && wbReg0_i == src) begin
            value = wbData0_i;
        end else begin
            value = rfData;
        end
        return value;
    endfunction

    assign rs0 = decInst0_i[25:21];
    assign rt0 = decInst0_i[20:16];
    assign rs1 = decInst1_i[25:21];
    assign rt1 = decInst1_i[20:16];

    always_comb begin
        decodeInst(decInst0_i, op0, dest0, imm0, useImm0, useRs0, useRt0);
        decodeInst(decInst1_i, op1, dest1, imm1, useImm1, useRs1, useRt1);
    end

    // fields only, pairFetch qualifies it with its own valid state
    assign splitNeeded_o = (dest0 != '0) &&
                           ((useRs1 && rs1 == dest0) || (useRt1 && rt1 == dest0));

    regFile u_rf (
        .clk      (clk),
        .raddr0_i (rs0),
        .raddr1_i (rt0),
        .raddr2_i (rs1),
        .raddr3_i (rt1),
        .rdata0_o (rfRs0),
        .rdata1_o (rfRt0),
        .rdata2_o (rfRs1),
        .rdata3_o (rfRt1),
        .we0_i    (wbValid0_i),
        .we1_i    (wbValid1_i),
        .waddr0_i (wbReg0_i),
        .waddr1_i (wbReg1_i),
        .wdata0_i (wbData0_i),
        .wdata1_i (wbData1_i)
    );

    always_comb begin
        srcA0 = useRs0 ? forwardSrc(rs0, rfRs0) : '0;
        srcA1 = useRs1 ? forwardSrc(rs1, rfRs1) : '0;
        srcB0 = useImm0 ? imm0 : (useRt0 ? forwardSrc(rt0, rfRt0) : '0);
        srcB1 = useImm1 ? imm1 : (useRt1 ? forwardSrc(rt1, rfRt1) : '0);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exValid0_o <= 1'b0;
            exValid1_o <= 1'b0;
        end else begin
            exValid0_o <= decValid0_i;
            exValid1_o <= decValid1_i;
        end
    end

    always_ff @(posedge clk) begin
        exOp0_o   <= op0;
        exA0_o    <= srcA0;
        exB0_o    <= srcB0;
        exDest0_o <= dest0;
        exPc0_o   <= decPc0_i;
        exOp1_o   <= op1;
        exA1_o    <= srcA1;
        exB1_o    <= srcB1;
        exDest1_o <= dest1;
        exPc1_o   <= decPc1_i;
    end

endmodule

// ==== rtl/pairFetch.sv ====
module pairFetch import dualIssuePkg::*; #(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  pairValid_i,
    input  word_t inst0_i,
    input  word_t inst1_i,
    input  logic  splitNeeded_i,
    output logic  pairReady_o,
    output logic  decValid0_o,
    output logic  decValid1_o,
    output word_t decInst0_o,
    output word_t decInst1_o,
    output word_t decPc0_o,
    output word_t decPc1_o
);

    typedef enum logic {
        FULL,
        FIRST_HALF
    } splitState_t;

    splitState_t state;
    logic        readyEn;       // low only while reset is applied
    logic        holdV0;
    logic        holdV1;
    logic        splitNow;
    logic        accept;
    word_t       pcNext;        // pc of the next pair to accept
    word_t       pcReg;

    // split only on the first decode cycle of a full pair
    assign splitNow    = (state == FULL) && holdV0 && holdV1 && splitNeeded_i;
    assign pairReady_o = readyEn && !splitNow;
    assign accept      = pairValid_i && pairReady_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state   <= FULL;
            readyEn <= 1'b0;
            holdV0  <= 1'b0;
            holdV1  <= 1'b0;
            pcNext  <= RESET_PC;
        end else begin
            readyEn <= 1'b1;
            if (splitNow) begin
                state <= FIRST_HALF; // lane 0 issued, lane 1 still waits in decode
            end else begin
                state  <= FULL;
                holdV0 <= accept;
                holdV1 <= accept;
                if (accept) begin
                    pcNext <= pcNext + word_t'(8);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decInst0_o <= inst0_i;
            decInst1_o <= inst1_i;
            pcReg      <= pcNext;
        end
    end

    // lane 0 becomes a bubble once the first half has gone
    assign decValid0_o = holdV0 && (state == FULL);
    assign decValid1_o = holdV1 && !splitNow;
    assign decPc0_o    = pcReg;
    assign decPc1_o    = pcReg + word_t'(4);

endmodule

// ==== rtl/regFile.sv ====
module regFile import dualIssuePkg::*; (
    input  logic     clk,
    input  regAddr_t raddr0_i,
    input  regAddr_t raddr1_i,
    input  regAddr_t raddr2_i,
    input  regAddr_t raddr3_i,
    output word_t    rdata0_o,
    output word_t    rdata1_o,
    output word_t    rdata2_o,
    output word_t    rdata3_o,
    input  logic     we0_i,
    input  logic     we1_i,
    input  regAddr_t waddr0_i,
    input  regAddr_t waddr1_i,
    input  word_t    wdata0_i,
    input  word_t    wdata1_i
);

    word_t regs [1 << REG_ADDR_W];

    // second write lands last, so lane 1 wins on a shared address
    always_ff @(posedge clk) begin
        if (we0_i && waddr0_i != '0) begin
            regs[waddr0_i] <= wdata0_i;
        end
        if (we1_i && waddr1_i != '0) begin
            regs[waddr1_i] <= wdata1_i;
        end
    end

    // r0 hardwired to zero
    assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
    assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i];

endmodule

// ==== rtl/dualIssuePkg.sv ====
package dualIssuePkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [DATA_W-1:0]     word_t;      // data, instructions and pcs
    typedef logic [REG_ADDR_W-1:0] regAddr_t;

    // major opcode field, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_t;

    // R-type function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI     // passes operand b, already shifted in decode
    } aluOp_t;

endpackage
